// File: Bender.yml
package:
  name: dma_client_axis_sink

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dma_sink_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/stream_write_ctrl.sv
      - hdl/ram_seg_writer.sv
      - hdl/completion_tracker.sv
      - hdl/dma_client_axis_sink.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_dma_client_axis_sink.sv

// File: bench/tb_dma_client_axis_sink.sv
// directed testbench for the stream sink DMA client with a segmented RAM model
`default_nettype none

`include "dma_sink_consts.svh"

module tb_dma_client_axis_sink;

    timeunit 1ns;
    timeprecision 1ps;

    import dma_sink_pkg::*;

    localparam int RAM_BYTES = 2 ** `RAM_ADDR_W;
    localparam int SCHED_LEN = 8;
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk;
    logic rst;
    logic enable;
    desc_req_t desc_req;
    logic desc_req_valid;
    logic desc_req_ready;
    desc_sts_t desc_sts;
    logic desc_sts_valid;
    axis_beat_t s_axis;
    logic s_axis_valid;
    logic s_axis_ready;
    seg_cmd_t [`RAM_SEGS-1:0] ram_wr_cmd;
    logic [`RAM_SEGS-1:0] ram_wr_cmd_valid;
    logic [`RAM_SEGS-1:0] ram_wr_cmd_ready;
    logic [`RAM_SEGS-1:0] ram_wr_done;

    logic [7:0] ram_mem [RAM_BYTES];
    logic [7:0] exp_mem [RAM_BYTES];
    int done_sched [`RAM_SEGS][SCHED_LEN];
    int done_backlog [`RAM_SEGS];
    int stall_pct = 20;
    desc_sts_t sts_got [$];
    desc_sts_t exp_sts [$];

    dma_client_axis_sink i_dut (
        .clk              (clk),
        .rst              (rst),
        .enable           (enable),
        .desc_req         (desc_req),
        .desc_req_valid   (desc_req_valid),
        .desc_req_ready   (desc_req_ready),
        .desc_sts         (desc_sts),
        .desc_sts_valid   (desc_sts_valid),
        .s_axis           (s_axis),
        .s_axis_valid     (s_axis_valid),
        .s_axis_ready     (s_axis_ready),
        .ram_wr_cmd       (ram_wr_cmd),
        .ram_wr_cmd_valid (ram_wr_cmd_valid),
        .ram_wr_cmd_ready (ram_wr_cmd_ready),
        .ram_wr_done      (ram_wr_done)
    );

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a ^ (a >> 3)) ^ 8'h5a;
    endfunction

    // bytes up to the first clear keep bit
    function automatic int keep_byte_count(input logic [`AXIS_KEEP_W-1:0] keep);
        int n;
        n = 0;
        while (n < `AXIS_KEEP_W && keep[n]) begin
            n++;
        end
        return n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // byte address is word address, then segment, then lane
    task automatic write_segment(input int seg, input seg_cmd_t cmd);
        int base;
        base = int'(cmd.addr) * `RAM_SEGS * `SEG_BE_W + seg * `SEG_BE_W;
        for (int j = 0; j < `SEG_BE_W; j++) begin
            if (cmd.be[j]) begin
                ram_mem[base + j] = cmd.data[8*j +: 8];
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // RAM model with random ready and completions one to three cycles after a write
    task automatic run_ram_model();
        int unsigned ram_cycle;
        int unsigned due;
        for (int s = 0; s < `RAM_SEGS; s++) begin
            done_backlog[s] = 0;
            for (int k = 0; k < SCHED_LEN; k++) begin
                done_sched[s][k] = 0;
            end
        end
        ram_cycle = 0;
        forever begin
            @(posedge clk);
            for (int s = 0; s < `RAM_SEGS; s++) begin
                if (!rst && ram_wr_cmd_valid[s] && ram_wr_cmd_ready[s]) begin
                    write_segment(s, ram_wr_cmd[s]);
                    due = (ram_cycle + 1 + $urandom_range(2)) % SCHED_LEN;
                    done_sched[s][due]++;
                end
            end
            #10;
            ram_cycle++;
            for (int s = 0; s < `RAM_SEGS; s++) begin
                done_backlog[s] += done_sched[s][ram_cycle % SCHED_LEN];
                done_sched[s][ram_cycle % SCHED_LEN] = 0;
                ram_wr_done[s] = done_backlog[s] > 0;
                if (done_backlog[s] > 0) begin
                    done_backlog[s]--;
                end
                ram_wr_cmd_ready[s] = !rst && ($urandom_range(99) >= stall_pct);
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (desc_sts_valid) begin
                sts_got.push_back(desc_sts);
            end
        end
    end

    initial begin
        int unsigned cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $fatal(1, "timeout");
    end

    task automatic offer_desc(input logic [`RAM_ADDR_W-1:0] dst, input int len,
                              input logic [`TAG_W-1:0] tag);
        desc_req.dst_addr = dst;
        desc_req.len = `LEN_W'(len);
        desc_req.tag = tag;
        desc_req_valid = 1'b1;
    endtask

    task automatic wait_desc_accept();
        @(posedge clk);
        while (!desc_req_ready) begin
            @(posedge clk);
        end
        #10;
        desc_req_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [31:0] data, input logic [3:0] keep, input logic last);
        s_axis.data = data;
        s_axis.keep = keep;
        s_axis.last = last;
        s_axis_valid = 1'b1;
        @(posedge clk);
        while (!s_axis_ready) begin
            @(posedge clk);
        end
        #10;
        s_axis_valid = 1'b0;
    endtask

    // expected bytes are the first min(len, tlast bytes) from the aligned address
    task automatic send_stream(input logic [`RAM_ADDR_W-1:0] dst, input int len,
                               input logic [`TAG_W-1:0] tag, input int nbeats,
                               input logic [3:0] last_keep);
        int base;
        int count;
        logic [31:0] data;
        desc_sts_t sts;
        base = int'(dst) & ~(`AXIS_KEEP_W - 1);
        count = `AXIS_KEEP_W * (nbeats - 1) + keep_byte_count(last_keep);
        if (count > len) begin
            count = len;
        end
        for (int b = 0; b < nbeats; b++) begin
            data = $urandom;
            for (int j = 0; j < `AXIS_KEEP_W; j++) begin
                if (b * `AXIS_KEEP_W + j < count) begin
                    exp_mem[base + b * `AXIS_KEEP_W + j] = data[8*j +: 8];
                end
            end
            send_beat(data, (b == nbeats - 1) ? last_keep : 4'hf, b == nbeats - 1);
        end
        sts.len = `LEN_W'(count);
        sts.tag = tag;
        exp_sts.push_back(sts);
    endtask

    task automatic run_xfer(input logic [`RAM_ADDR_W-1:0] dst, input int len,
                            input logic [`TAG_W-1:0] tag, input int nbeats,
                            input logic [3:0] last_keep);
        offer_desc(dst, len, tag);
        wait_desc_accept();
        send_stream(dst, len, tag, nbeats, last_keep);
    endtask

    task automatic collect_statuses();
        desc_sts_t got;
        desc_sts_t want;
        while (sts_got.size() < exp_sts.size()) begin
            @(posedge clk);
            #10;
        end
        // give any extra status a few cycles to show up
        repeat (4) begin
            @(posedge clk);
            #10;
        end
        check_value("number of statuses", sts_got.size(), exp_sts.size());
        while (exp_sts.size() > 0) begin
            got = sts_got.pop_front();
            want = exp_sts.pop_front();
            check_value("status byte count", got.len, want.len);
            check_value("status tag", got.tag, want.tag);
        end
        for (int a = 0; a < RAM_BYTES; a++) begin
            check_value($sformatf("RAM byte %0h", a), ram_mem[a], exp_mem[a]);
        end
    endtask

    task automatic aligned_full_transfer();
        run_xfer(11'h040, 16, 4'h3, 4, 4'hf);
        run_xfer(11'h104, 16, 4'h5, 4, 4'hf);
        collect_statuses();
    endtask

    task automatic unaligned_length_transfer();
        // low address bits are dropped, so the data lands at 0x0a0
        run_xfer(11'h0a2, 10, 4'h6, 3, 4'hf);
        collect_statuses();
    endtask

    task automatic early_last_transfer();
        run_xfer(11'h200, 32, 4'h7, 3, 4'b0011);
        collect_statuses();
    endtask

    task automatic excess_data_transfer();
        run_xfer(11'h300, 8, 4'h9, 5, 4'hf);
        run_xfer(11'h320, 12, 4'ha, 3, 4'hf);
        collect_statuses();
    endtask

    task automatic backpressure_queueing();
        int len;
        int nbeats;
        stall_pct = 70;
        for (int i = 0; i < 6; i++) begin
            len = $urandom_range(40, 1);
            nbeats = (len + `AXIS_KEEP_W - 1) / `AXIS_KEEP_W + ((i % 2) ? 2 : 0);
            run_xfer(11'h400 + 11'(i * 'h40) + 11'($urandom_range(3)), len,
                     `TAG_W'(i + 8), nbeats, 4'hf);
        end
        collect_statuses();
        stall_pct = 20;
    endtask

    task automatic enable_gating();
        enable = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #10;
        end
        offer_desc(11'h600, 20, 4'hc);
        repeat (50) begin
            @(posedge clk);
            check_value("desc_req_ready while disabled", desc_req_ready, 0);
            check_value("desc_sts_valid while disabled", desc_sts_valid, 0);
        end
        #10;
        enable = 1'b1;
        wait_desc_accept();
        send_stream(11'h600, 20, 4'hc, 5, 4'hf);
        collect_statuses();
    endtask

    initial begin
        void'($urandom(32'he798_7de3));
        rst = 1'b1;
        enable = 1'b1;
        desc_req = '0;
        desc_req_valid = 1'b0;
        s_axis = '0;
        s_axis_valid = 1'b0;
        ram_wr_cmd_ready = '0;
        ram_wr_done = '0;
        for (int a = 0; a < RAM_BYTES; a++) begin
            ram_mem[a] = fill_byte(a);
            exp_mem[a] = fill_byte(a);
        end
        fork
            run_ram_model();
        join_none
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;

        aligned_full_transfer();
        unaligned_length_transfer();
        early_last_transfer();
        excess_data_transfer();
        backpressure_queueing();
        enable_gating();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/completion_tracker.sv
// in-order status queue, in-flight descriptor count and status output
`default_nettype none

`include "dma_sink_consts.svh"

module completion_tracker (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire dma_sink_pkg::status_entry_t status_entry,
    input  wire logic                        status_we,
    output logic                             status_half_full,
    input  wire logic                        desc_start,
    output logic                             slot_avail,
    input  wire logic [`RAM_SEGS-1:0]        seg_done,
    output logic [`RAM_SEGS-1:0]             seg_done_ack,
    output dma_sink_pkg::desc_sts_t          desc_sts,
    output logic                             desc_sts_valid
);

    import dma_sink_pkg::*;

    localparam int MAX_ACTIVE = 2 ** `STATUS_FIFO_AW;

    status_entry_t q_head;
    logic          q_empty;
    logic          q_full;
    logic          pop;
    logic          desc_end;

    logic [`STATUS_FIFO_AW:0] active_count;

    // head may retire once every segment it touched has a pending completion
    assign pop = !q_empty && ((q_head.mask & ~seg_done) == '0);
    assign desc_end = pop && q_head.last;
    assign seg_done_ack = pop ? q_head.mask : '0;

    sync_fifo #(
        .payload_t (status_entry_t)
    ) i_status_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (status_we && !q_full),
        .wr_data   (status_entry),
        .rd_en     (pop),
        .rd_data   (q_head),
        .empty     (q_empty),
        .full      (q_full),
        .half_full (status_half_full)
    );

    always_ff @(posedge clk) begin
        if (desc_end) begin
            desc_sts.len <= q_head.len;
            desc_sts.tag <= q_head.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_sts_valid <= 1'b0;
            active_count <= '0;
            slot_avail <= 1'b1;
        end else begin
            desc_sts_valid <= desc_end;

            case ({desc_start, desc_end})
                2'b10: begin
                    active_count <= active_count + 1'b1;
                    slot_avail <= active_count < (`STATUS_FIFO_AW + 1)'(MAX_ACTIVE - 1);
                end
                2'b01: begin
                    active_count <= active_count - 1'b1;
                    slot_avail <= 1'b1;
                end
                default: begin
                    slot_avail <= active_count < (`STATUS_FIFO_AW + 1)'(MAX_ACTIVE);
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/dma_client_axis_sink.sv
// stream sink DMA client top level with controller, segment writers and completion tracker
`default_nettype none

`include "dma_sink_consts.svh"

module dma_client_axis_sink (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               enable,
    input  wire dma_sink_pkg::desc_req_t            desc_req,
    input  wire logic                               desc_req_valid,
    output logic                                    desc_req_ready,
    output dma_sink_pkg::desc_sts_t                 desc_sts,
    output logic                                    desc_sts_valid,
    input  wire dma_sink_pkg::axis_beat_t           s_axis,
    input  wire logic                               s_axis_valid,
    output logic                                    s_axis_ready,
    output dma_sink_pkg::seg_cmd_t [`RAM_SEGS-1:0]  ram_wr_cmd,
    output logic [`RAM_SEGS-1:0]                    ram_wr_cmd_valid,
    input  wire logic [`RAM_SEGS-1:0]               ram_wr_cmd_ready,
    input  wire logic [`RAM_SEGS-1:0]               ram_wr_done
);

    import dma_sink_pkg::*;

    seg_cmd_t [`RAM_SEGS-1:0] seg_cmd;
    logic [`RAM_SEGS-1:0]     seg_cmd_valid;
    logic [`RAM_SEGS-1:0]     seg_ready;
    logic [`RAM_SEGS-1:0]     seg_done;
    logic [`RAM_SEGS-1:0]     seg_done_ack;
    status_entry_t            status_entry;
    logic                     status_we;
    logic                     status_half_full;
    logic                     slot_avail;
    logic                     desc_start;

    stream_write_ctrl i_ctrl (
        .clk              (clk),
        .rst              (rst),
        .enable           (enable),
        .desc_req         (desc_req),
        .desc_req_valid   (desc_req_valid),
        .desc_req_ready   (desc_req_ready),
        .s_axis           (s_axis),
        .s_axis_valid     (s_axis_valid),
        .s_axis_ready     (s_axis_ready),
        .seg_cmd          (seg_cmd),
        .seg_cmd_valid    (seg_cmd_valid),
        .seg_ready        (seg_ready),
        .status_entry     (status_entry),
        .status_we        (status_we),
        .status_half_full (status_half_full),
        .slot_avail       (slot_avail),
        .desc_start       (desc_start)
    );

    for (genvar g = 0; g < `RAM_SEGS; g++) begin : g_seg
        ram_seg_writer i_writer (
            .clk           (clk),
            .rst           (rst),
            .cmd_in        (seg_cmd[g]),
            .cmd_in_valid  (seg_cmd_valid[g]),
            .cmd_ready     (seg_ready[g]),
            .ram_cmd       (ram_wr_cmd[g]),
            .ram_cmd_valid (ram_wr_cmd_valid[g]),
            .ram_cmd_ready (ram_wr_cmd_ready[g]),
            .ram_done      (ram_wr_done[g]),
            .done          (seg_done[g]),
            .done_ack      (seg_done_ack[g])
        );
    end

    completion_tracker i_tracker (
        .clk              (clk),
        .rst              (rst),
        .status_entry     (status_entry),
        .status_we        (status_we),
        .status_half_full (status_half_full),
        .desc_start       (desc_start),
        .slot_avail       (slot_avail),
        .seg_done         (seg_done),
        .seg_done_ack     (seg_done_ack),
        .desc_sts         (desc_sts),
        .desc_sts_valid   (desc_sts_valid)
    );

endmodule

`default_nettype wire

// File: hdl/dma_sink_consts.svh
// segment geometry, stream and descriptor widths, queue depths
`ifndef DMA_SINK_CONSTS_SVH
`define DMA_SINK_CONSTS_SVH

// segmented RAM write port
`define RAM_SEGS 2
`define SEG_DATA_W 32
`define SEG_BE_W 4
`define SEG_ADDR_W 8

// byte address covers segment word address plus byte offset in the full RAM word
`define RAM_ADDR_W 11

// stream beat
`define AXIS_DATA_W 32
`define AXIS_KEEP_W 4

// descriptor fields
`define LEN_W 12
`define TAG_W 4

// status queue depth also sets the in-flight descriptor limit
`define STATUS_FIFO_AW 5

// per-segment command FIFO
`define OUT_FIFO_AW 5

`endif

// File: hdl/dma_sink_pkg.sv
// descriptor, status, stream beat, segment command and status queue entry types
`default_nettype none

`include "dma_sink_consts.svh"

package dma_sink_pkg;

    typedef struct packed {
        logic [`RAM_ADDR_W-1:0] dst_addr;
        logic [`LEN_W-1:0]      len;
        logic [`TAG_W-1:0]      tag;
    } desc_req_t;

    typedef struct packed {
        logic [`LEN_W-1:0] len;
        logic [`TAG_W-1:0] tag;
    } desc_sts_t;

    typedef struct packed {
        logic [`AXIS_DATA_W-1:0] data;
        logic [`AXIS_KEEP_W-1:0] keep;
        logic                    last;
    } axis_beat_t;

    typedef struct packed {
        logic [`SEG_BE_W-1:0]   be;
        logic [`SEG_ADDR_W-1:0] addr;
        logic [`SEG_DATA_W-1:0] data;
    } seg_cmd_t;

    // one entry per accepted beat, mask marks segments the beat wrote
    typedef struct packed {
        logic [`LEN_W-1:0]    len;
        logic [`TAG_W-1:0]    tag;
        logic [`RAM_SEGS-1:0] mask;
        logic                 last;
    } status_entry_t;

endpackage

`default_nettype wire

// File: hdl/ram_seg_writer.sv
// one RAM segment: command FIFO, output register and write completion counter
`default_nettype none

`include "dma_sink_consts.svh"

module ram_seg_writer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire dma_sink_pkg::seg_cmd_t cmd_in,
    input  wire logic                   cmd_in_valid,
    output logic                        cmd_ready,
    output dma_sink_pkg::seg_cmd_t      ram_cmd,
    output logic                        ram_cmd_valid,
    input  wire logic                   ram_cmd_ready,
    input  wire logic                   ram_done,
    output logic                        done,
    input  wire logic                   done_ack
);

    import dma_sink_pkg::*;

    localparam int MAX_COUNT = 2 ** `OUT_FIFO_AW;

    seg_cmd_t fifo_head;
    logic     fifo_empty;
    logic     fifo_full;
    logic     fifo_half_full;
    logic     load;

    logic [`OUT_FIFO_AW:0] done_count;

    // refill the output register when it is free or being taken this cycle
    assign load = !fifo_empty && (!ram_cmd_valid || ram_cmd_ready);
    assign cmd_ready = !fifo_half_full;
    assign done = done_count != '0;

    sync_fifo #(
        .payload_t (seg_cmd_t)
    ) i_cmd_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (cmd_in_valid && !fifo_full),
        .wr_data   (cmd_in),
        .rd_en     (load),
        .rd_data   (fifo_head),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .half_full (fifo_half_full)
    );

    always_ff @(posedge clk) begin
        if (load) begin
            ram_cmd <= fifo_head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_cmd_valid <= 1'b0;
            done_count <= '0;
        end else begin
            if (load) begin
                ram_cmd_valid <= 1'b1;
            end else if (ram_cmd_ready) begin
                ram_cmd_valid <= 1'b0;
            end

            // a completion and an ack in the same cycle cancel out
            if (ram_done && !done_ack && done_count < (`OUT_FIFO_AW + 1)'(MAX_COUNT)) begin
                done_count <= done_count + 1'b1;
            end else if (!ram_done && done_ack && done_count != '0) begin
                done_count <= done_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/stream_write_ctrl.sv
// descriptor and beat FSM producing segment write commands and status queue entries
`default_nettype none

`include "dma_sink_consts.svh"

module stream_write_ctrl (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    input  wire logic                                  enable,
    input  wire dma_sink_pkg::desc_req_t               desc_req,
    input  wire logic                                  desc_req_valid,
    output logic                                       desc_req_ready,
    input  wire dma_sink_pkg::axis_beat_t              s_axis,
    input  wire logic                                  s_axis_valid,
    output logic                                       s_axis_ready,
    output dma_sink_pkg::seg_cmd_t [`RAM_SEGS-1:0]     seg_cmd,
    output logic [`RAM_SEGS-1:0]                       seg_cmd_valid,
    input  wire logic [`RAM_SEGS-1:0]                  seg_ready,
    output dma_sink_pkg::status_entry_t                status_entry,
    output logic                                       status_we,
    input  wire logic                                  status_half_full,
    input  wire logic                                  slot_avail,
    output logic                                       desc_start
);

    import dma_sink_pkg::*;

    localparam int OFFSET_W = $clog2(`AXIS_KEEP_W);
    localparam int BE_ALL_W = `RAM_SEGS * `SEG_BE_W;
    localparam int WORD_OFF_W = $clog2(BE_ALL_W);
    localparam int PART_COUNT = BE_ALL_W / `AXIS_KEEP_W;
    localparam int CC_W = `LEN_W - OFFSET_W + 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_DROP
    } state_t;

    state_t state, state_next;

    logic [`RAM_ADDR_W-1:0]  addr, addr_next;
    logic [`AXIS_KEEP_W-1:0] keep_mask, keep_mask_next;
    logic [OFFSET_W-1:0]     last_offset, last_offset_next;
    logic [`LEN_W-1:0]       length, length_next;
    logic [CC_W-1:0]         cycle_count, cycle_count_next;
    logic                    last_cycle, last_cycle_next;
    logic [`TAG_W-1:0]       tag, tag_next;
    logic                    desc_req_ready_next;
    logic                    s_axis_ready_next;

    logic [`AXIS_KEEP_W-1:0]            keep_trim;
    logic [BE_ALL_W-1:0]                be_all;
    logic [`RAM_SEGS*`SEG_DATA_W-1:0]   data_all;
    logic [`RAM_SEGS-1:0]               seg_mask;
    logic [OFFSET_W:0]                  cycle_size;
    logic                               space_ok;
    logic                               entry_last;

    // byte mask for a beat, trimmed on the final beat of the descriptor
    function automatic logic [`AXIS_KEEP_W-1:0] trim_mask(input logic last,
                                                          input logic [OFFSET_W-1:0] off);
        if (last && off != '0) begin
            return {`AXIS_KEEP_W{1'b1}} >> (`AXIS_KEEP_W - off);
        end else begin
            return '1;
        end
    endfunction

    always_comb begin
        state_next = state;
        addr_next = addr;
        keep_mask_next = keep_mask;
        last_offset_next = last_offset;
        length_next = length;
        cycle_count_next = cycle_count;
        last_cycle_next = last_cycle;
        tag_next = tag;
        desc_req_ready_next = 1'b0;
        s_axis_ready_next = 1'b0;
        desc_start = 1'b0;
        status_we = 1'b0;
        entry_last = 1'b0;
        seg_cmd_valid = '0;
        cycle_size = (OFFSET_W + 1)'(`AXIS_KEEP_W);

        // place the beat in the half of the RAM word picked by the address
        keep_trim = s_axis.keep & keep_mask;
        be_all = BE_ALL_W'(keep_trim) << addr[WORD_OFF_W-1:0];
        data_all = {PART_COUNT{s_axis.data}};
        for (int i = 0; i < `RAM_SEGS; i++) begin
            seg_cmd[i].be = be_all[i*`SEG_BE_W +: `SEG_BE_W];
            seg_cmd[i].addr = addr[`RAM_ADDR_W-1 -: `SEG_ADDR_W];
            seg_cmd[i].data = data_all[i*`SEG_DATA_W +: `SEG_DATA_W];
            seg_mask[i] = |seg_cmd[i].be;
        end

        space_ok = &seg_ready && !status_half_full;

        case (state)
            ST_IDLE: begin
                desc_req_ready_next = enable && slot_avail;
                if (desc_req_ready && desc_req_valid) begin
                    addr_next = {desc_req.dst_addr[`RAM_ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
                    last_offset_next = desc_req.len[OFFSET_W-1:0];
                    tag_next = desc_req.tag;
                    length_next = '0;
                    cycle_count_next = CC_W'((desc_req.len - `LEN_W'(1)) >> OFFSET_W);
                    last_cycle_next = cycle_count_next == '0;
                    keep_mask_next = trim_mask(last_cycle_next, last_offset_next);
                    desc_req_ready_next = 1'b0;
                    s_axis_ready_next = space_ok;
                    desc_start = 1'b1;
                    state_next = ST_WRITE;
                end
            end
            ST_WRITE: begin
                s_axis_ready_next = space_ok;
                if (s_axis_ready && s_axis_valid) begin
                    addr_next = addr + `RAM_ADDR_W'(`AXIS_KEEP_W);
                    length_next = length + `LEN_W'(`AXIS_KEEP_W);
                    cycle_count_next = cycle_count - 1'b1;
                    last_cycle_next = cycle_count_next == '0;
                    keep_mask_next = trim_mask(last_cycle_next, last_offset);
                    seg_cmd_valid = seg_mask;
                    status_we = 1'b1;

                    if (s_axis.last) begin
                        // early end, count bytes up to the first clear keep bit
                        for (int i = `AXIS_KEEP_W - 1; i >= 0; i--) begin
                            if (!keep_trim[i]) begin
                                cycle_size = (OFFSET_W + 1)'(i);
                            end
                        end
                        length_next = length + `LEN_W'(cycle_size);
                        entry_last = 1'b1;
                        s_axis_ready_next = 1'b0;
                        state_next = ST_IDLE;
                    end else if (last_cycle) begin
                        if (last_offset != '0) begin
                            length_next = length + `LEN_W'(last_offset);
                        end
                        entry_last = 1'b1;
                        s_axis_ready_next = 1'b1;
                        state_next = ST_DROP;
                    end
                end
            end
            ST_DROP: begin
                // length used up, swallow beats until tlast
                s_axis_ready_next = 1'b1;
                if (s_axis_ready && s_axis_valid && s_axis.last) begin
                    s_axis_ready_next = 1'b0;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase

        status_entry.len = length_next;
        status_entry.tag = tag;
        status_entry.mask = seg_mask;
        status_entry.last = entry_last;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            desc_req_ready <= 1'b0;
            s_axis_ready <= 1'b0;
        end else begin
            state <= state_next;
            desc_req_ready <= desc_req_ready_next;
            s_axis_ready <= s_axis_ready_next;
        end
    end

    always_ff @(posedge clk) begin
        addr <= addr_next;
        keep_mask <= keep_mask_next;
        last_offset <= last_offset_next;
        length <= length_next;
        cycle_count <= cycle_count_next;
        last_cycle <= last_cycle_next;
        tag <= tag_next;
    end

endmodule

`default_nettype wire

// File: hdl/sync_fifo.sv
// synchronous FIFO over a generic payload type with empty, full and half-full flags
`default_nettype none

`include "dma_sink_consts.svh"

module sync_fifo #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     wr_en,
    input  wire payload_t wr_data,
    input  wire logic     rd_en,
    output payload_t      rd_data,
    output logic          empty,
    output logic          full,
    output logic          half_full
);

    // sized for the deeper of the two queues that use it
    localparam int AW = (`STATUS_FIFO_AW > `OUT_FIFO_AW) ? `STATUS_FIFO_AW : `OUT_FIFO_AW;
    localparam int DEPTH = 2 ** AW;

    payload_t mem [DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] level;

    assign level = wr_ptr - rd_ptr;
    assign empty = wr_ptr == rd_ptr;
    assign full = wr_ptr == (rd_ptr ^ {1'b1, {AW{1'b0}}});
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            half_full <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // lags the pointers by a cycle
            half_full <= level >= (AW + 1)'(DEPTH / 2);
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/dma_sink_pkg.sv
hdl/sync_fifo.sv
hdl/stream_write_ctrl.sv
hdl/ram_seg_writer.sv
hdl/completion_tracker.sv
hdl/dma_client_axis_sink.sv
bench/tb_dma_client_axis_sink.sv
